//--- common/dino_pkg.sv
package dino_pkg;

	// Screen coordinate widths for a 320x240 field
	localparam int X_W = 9;
	localparam int Y_W = 8;

	typedef logic [X_W-1:0] x_t;
	typedef logic [Y_W-1:0] y_t;
	typedef logic signed [9:0] vel_t; // Negative is upward
	typedef logic [15:0] score_t;

	localparam x_t SCREEN_W = 9'd320;

	// Fixed positions, rows grow downward
	localparam x_t DINO_X = 9'd52;
	localparam y_t GROUND_Y = 8'd109;
	localparam y_t OBS_Y = 8'd109;
	localparam x_t OBS_START = 9'd288;
	localparam x_t OBS_STEP = 9'd4; // Pixels per game tick

	// Same box for dinosaur and obstacle
	localparam x_t HB_W = 9'd20;
	localparam y_t HB_H = 8'd30;

	localparam vel_t JUMP_VEL = -10'sd10;
	localparam vel_t GRAVITY = 10'sd1;

	localparam int TICK_CYCLES = 64; // Clock cycles per game tick

	// 50 MHz / (115200 * 16)
	localparam int OS_DIV = 27;

	localparam logic [7:0] CMD_JUMP = 8'h4A; // ASCII J

	localparam int DIGITS = 3;

endpackage

//--- common/playfield_if.sv
`timescale 1ns/1ps

interface playfield_if;

	logic game_tick; // Strobes from the referee
	logic new_round;
	logic respawn;

	dino_pkg::y_t dino_y;
	dino_pkg::x_t obstacle_x;
	logic obstacle_passed; // Same cycle as the crossing step

	modport referee (
		output game_tick, new_round, respawn,
		input dino_y, obstacle_x, obstacle_passed
	);

	modport dino (input game_tick, new_round, output dino_y);

	modport obstacle (
		input game_tick, new_round, respawn,
		output obstacle_x, obstacle_passed
	);

endinterface

//--- game/dino_physics.sv
`timescale 1ns/1ps

module dino_physics (
	input logic Clock,
	input logic rst_n,
	input logic jump,
	playfield_if.dino pf
);

	logic in_air;
	dino_pkg::vel_t vel;
	logic signed [dino_pkg::Y_W+2:0] next_y; // Room for the sign and an overshoot

	assign next_y = $signed({3'b000, pf.dino_y}) + vel;

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			pf.dino_y <= dino_pkg::GROUND_Y;
			vel <= '0;
			in_air <= 1'b0;
		end else if (pf.new_round) begin
			pf.dino_y <= dino_pkg::GROUND_Y;
			vel <= '0;
			in_air <= 1'b0;
		end else if (jump && !in_air) begin
			// Row stays put until the next tick
			vel <= dino_pkg::JUMP_VEL;
			in_air <= 1'b1;
		end else if (pf.game_tick && in_air) begin
			if (next_y >= $signed({3'b000, dino_pkg::GROUND_Y})) begin
				pf.dino_y <= dino_pkg::GROUND_Y; // Landed
				vel <= '0;
				in_air <= 1'b0;
			end else begin
				pf.dino_y <= next_y[dino_pkg::Y_W-1:0];
				vel <= vel + dino_pkg::GRAVITY;
			end
		end
	end

	// Dinosaur never sinks below the ground line
	dino_above_ground: assert property (@(posedge Clock) disable iff (!rst_n)
		pf.dino_y <= dino_pkg::GROUND_Y);

endmodule

//--- game/obstacle_mover.sv
`timescale 1ns/1ps

module obstacle_mover (
	input logic Clock,
	input logic rst_n,
	playfield_if.obstacle pf
);

	dino_pkg::x_t step_x;

	// Wrap back to the start column near the left edge
	assign step_x = (pf.obstacle_x <= dino_pkg::OBS_STEP) ? dino_pkg::OBS_START
		: pf.obstacle_x - dino_pkg::OBS_STEP;

	// A wrap never counts as a pass since step_x is then far right
	assign pf.obstacle_passed = pf.game_tick && (pf.obstacle_x > dino_pkg::DINO_X)
		&& (step_x <= dino_pkg::DINO_X);

	always_ff @(posedge Clock) begin
		if (!rst_n)
			pf.obstacle_x <= dino_pkg::OBS_START;
		else if (pf.new_round || pf.respawn)
			pf.obstacle_x <= dino_pkg::OBS_START;
		else if (pf.game_tick)
			pf.obstacle_x <= step_x;
	end

endmodule

//--- game/referee.sv
`timescale 1ns/1ps

module referee (
	input logic Clock,
	input logic rst_n,
	input logic restart,
	playfield_if.referee pf,
	output dino_pkg::score_t score,
	output dino_pkg::score_t high_score,
	output logic game_over
);

	logic [$clog2(dino_pkg::TICK_CYCLES+1)-1:0] tick_cnt; // Counts down to the next tick
	logic collision;

	// Runs on during game over so the tick phase is kept
	always_ff @(posedge Clock) begin
		if (!rst_n)
			tick_cnt <= ($clog2(dino_pkg::TICK_CYCLES+1))'(dino_pkg::TICK_CYCLES);
		else if (tick_cnt == '0)
			tick_cnt <= ($clog2(dino_pkg::TICK_CYCLES+1))'(dino_pkg::TICK_CYCLES - 1);
		else
			tick_cnt <= tick_cnt - 1'b1;
	end

	assign pf.game_tick = (tick_cnt == '0) && !game_over;
	assign pf.new_round = restart; // Positions reset on the same edge as the score

	// Columns within HB_W, and dinosaur bottom at the obstacle top or lower
	assign collision = (dino_pkg::DINO_X + dino_pkg::HB_W >= pf.obstacle_x)
		&& (dino_pkg::DINO_X <= pf.obstacle_x + dino_pkg::HB_W)
		&& (pf.dino_y + dino_pkg::HB_H >= dino_pkg::OBS_Y);

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			game_over <= 1'b0;
			score <= '0;
			high_score <= '0;
			pf.respawn <= 1'b0;
		end else begin
			pf.respawn <= 1'b0;
			if (restart) begin
				game_over <= 1'b0; // High score survives a restart
				score <= '0;
			end else if (!game_over) begin
				if (collision) begin
					game_over <= 1'b1;
					if (score > high_score)
						high_score <= score;
				end else if (pf.obstacle_passed) begin
					score <= score + 1'b1;
					pf.respawn <= 1'b1;
				end
			end
		end
	end

	score_frozen: assert property (@(posedge Clock) disable iff (!rst_n)
		game_over && !restart |=> $stable(score));

endmodule

//--- hw/dino_game_top.sv
`timescale 1ns/1ps

module dino_game_top (
	input logic Clock,
	input logic rst_n,
	input logic uart_rxd,
	input logic jump_key_n,
	input logic restart_key_n,
	output dino_pkg::y_t dino_y,
	output dino_pkg::x_t obstacle_x,
	output dino_pkg::score_t score,
	output dino_pkg::score_t high_score,
	output logic game_over,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5
);

	logic rx_valid;
	logic [7:0] rx_data;
	logic jump;
	logic restart;

	playfield_if pf ();

	uart_rx u_uart_rx (
		.Clock(Clock),
		.rst_n(rst_n),
		.rxd(uart_rxd),
		.rx_valid(rx_valid),
		.rx_data(rx_data)
	);

	command_decoder u_command_decoder (
		.Clock(Clock),
		.rst_n(rst_n),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.jump_key_n(jump_key_n),
		.restart_key_n(restart_key_n),
		.jump(jump),
		.restart(restart)
	);

	dino_physics u_dino_physics (.Clock(Clock), .rst_n(rst_n), .jump(jump), .pf(pf.dino));

	obstacle_mover u_obstacle_mover (.Clock(Clock), .rst_n(rst_n), .pf(pf.obstacle));

	referee u_referee (
		.Clock(Clock),
		.rst_n(rst_n),
		.restart(restart),
		.pf(pf.referee),
		.score(score),
		.high_score(high_score),
		.game_over(game_over)
	);

	score_display u_score_display (
		.score(score),
		.high_score(high_score),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.hex4(hex4),
		.hex5(hex5)
	);

	assign dino_y = pf.dino_y;
	assign obstacle_x = pf.obstacle_x;

endmodule

//--- hw/score_display.sv
`timescale 1ns/1ps

module score_display (
	input dino_pkg::score_t score,
	input dino_pkg::score_t high_score,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5
);

	logic [dino_pkg::DIGITS-1:0][6:0] score_seg; // Ones first
	logic [dino_pkg::DIGITS-1:0][6:0] high_seg;

	// Segments g down to a, lit when low
	function automatic logic [6:0] seg7(input logic [3:0] digit);
		case (digit)
			4'd0: return 7'b1000000;
			4'd1: return 7'b1111001;
			4'd2: return 7'b0100100;
			4'd3: return 7'b0110000;
			4'd4: return 7'b0011001;
			4'd5: return 7'b0010010;
			4'd6: return 7'b0000010;
			4'd7: return 7'b1111000;
			4'd8: return 7'b0000000;
			4'd9: return 7'b0010000;
			default: return 7'b1111111;
		endcase
	endfunction

	always_comb begin
		dino_pkg::score_t s_rem;
		dino_pkg::score_t h_rem;
		s_rem = score;
		h_rem = high_score;
		for (int i = 0; i < dino_pkg::DIGITS; i++) begin
			score_seg[i] = seg7(4'(s_rem % 16'd10));
			high_seg[i] = seg7(4'(h_rem % 16'd10));
			s_rem = s_rem / 16'd10;
			h_rem = h_rem / 16'd10;
		end
	end

	assign hex0 = score_seg[0];
	assign hex1 = score_seg[1];
	assign hex2 = score_seg[2];
	assign hex3 = high_seg[0];
	assign hex4 = high_seg[1];
	assign hex5 = high_seg[2];

endmodule

//--- test/game_model.svh
// Game state as it stands after each clock edge that samples a tick

int exp_x;
int exp_y;
int exp_vel; // Negative is upward
logic exp_air;
int exp_score;
int exp_high;
logic exp_over;

// Active-low code of one decimal digit
function automatic logic [6:0] seg_code(input int digit);
	logic [6:0] lit; // Segments g down to a, high when lit
	case (digit)
		0: lit = 7'h3F;
		1: lit = 7'h06;
		2: lit = 7'h5B;
		3: lit = 7'h4F;
		4: lit = 7'h66;
		5: lit = 7'h6D;
		6: lit = 7'h7D;
		7: lit = 7'h07;
		8: lit = 7'h7F;
		9: lit = 7'h6F;
		default: lit = 7'h00;
	endcase
	return ~lit;
endfunction

// Boxes overlap in x and the dinosaur reaches down to the obstacle top
function automatic logic collides(input int x, input int y);
	return (x >= int'(dino_pkg::DINO_X) - int'(dino_pkg::HB_W))
		&& (x <= int'(dino_pkg::DINO_X) + int'(dino_pkg::HB_W))
		&& (y + int'(dino_pkg::HB_H) >= int'(dino_pkg::OBS_Y));
endfunction

task automatic begin_round();
	exp_over = 1'b0;
	exp_score = 0;
	exp_x = int'(dino_pkg::OBS_START);
	exp_y = int'(dino_pkg::GROUND_Y);
	exp_vel = 0;
	exp_air = 1'b0;
endtask

task automatic clear_model();
	begin_round();
	exp_high = 0;
endtask

// Only a grounded dinosaur takes off
task automatic take_off();
	if (!exp_air) begin
		exp_air = 1'b1;
		exp_vel = int'(dino_pkg::JUMP_VEL);
	end
endtask

task automatic step_game();
	int old_x;
	logic passed;
	if (!exp_over) begin
		old_x = exp_x;
		if (exp_x <= int'(dino_pkg::OBS_STEP))
			exp_x = int'(dino_pkg::OBS_START); // Wrap at the left edge
		else
			exp_x = exp_x - int'(dino_pkg::OBS_STEP);
		passed = (old_x > int'(dino_pkg::DINO_X)) && (exp_x <= int'(dino_pkg::DINO_X));
		if (exp_air) begin
			if (exp_y + exp_vel >= int'(dino_pkg::GROUND_Y)) begin
				exp_y = int'(dino_pkg::GROUND_Y);
				exp_vel = 0;
				exp_air = 1'b0;
			end else begin
				exp_y = exp_y + exp_vel;
				exp_vel = exp_vel + int'(dino_pkg::GRAVITY);
			end
		end
		if (passed)
			exp_score++;
		// Collision seen one edge after the step, score already counted
		if (collides(exp_x, exp_y)) begin
			exp_over = 1'b1;
			if (exp_score > exp_high)
				exp_high = exp_score;
		end
		if (passed)
			exp_x = int'(dino_pkg::OBS_START); // Respawn
	end
endtask

//--- test/tb_dino_game.sv
`timescale 1ns/1ps

module tb_dino_game;

	localparam int BIT_CYCLES = dino_pkg::OS_DIV * 16;
	localparam int NUM_TICKS = 1200;
	localparam int FRAME_TICKS = 68; // One 8N1 frame, rounded up to whole ticks
	localparam int UART_LAG_TICKS = 64; // Jump from a byte lands in this tick interval
	localparam int TIMEOUT_CYCLES = (NUM_TICKS + 4) * dino_pkg::TICK_CYCLES + 200;

	// Cycles after a tick edge, chosen so no event lands on a tick edge
	localparam int KEY_PHASE = 4;
	localparam int KEY_UP_PHASE = 12;
	localparam int RESTART_PHASE = 44;
	localparam int RESTART_UP_PHASE = 52;
	localparam int CHECK_PHASE = 60;

	logic Clock;
	logic rst_n;
	logic uart_rxd;
	logic jump_key_n;
	logic restart_key_n;
	dino_pkg::y_t dino_y;
	dino_pkg::x_t obstacle_x;
	dino_pkg::score_t score;
	dino_pkg::score_t high_score;
	logic game_over;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex2;
	logic [6:0] hex3;
	logic [6:0] hex4;
	logic [6:0] hex5;

	logic [15:0] lfsr = 16'd83;
	int cycle_count;
	int tick_num;
	int uart_next_tick;
	int uart_jump_tick;

	`include "game_model.svh"

	dino_game_top dut0 (
		.Clock(Clock),
		.rst_n(rst_n),
		.uart_rxd(uart_rxd),
		.jump_key_n(jump_key_n),
		.restart_key_n(restart_key_n),
		.dino_y(dino_y),
		.obstacle_x(obstacle_x),
		.score(score),
		.high_score(high_score),
		.game_over(game_over),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.hex4(hex4),
		.hex5(hex5)
	);

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	// Galois LFSR, one step per bit taken
	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[14:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return val;
	endfunction

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	// 8N1 frame, LSB first
	task automatic send_byte(input logic [7:0] data);
		uart_rxd <= 1'b0;
		repeat (BIT_CYCLES) @(posedge Clock);
		for (int i = 0; i < 8; i++) begin
			uart_rxd <= data[i];
			repeat (BIT_CYCLES) @(posedge Clock);
		end
		uart_rxd <= 1'b1; // Stop bit, then idle
	endtask

	task automatic check_outputs();
		logic [6:0] hex_got [6];
		int value;
		int digit;
		hex_got[0] = hex0;
		hex_got[1] = hex1;
		hex_got[2] = hex2;
		hex_got[3] = hex3;
		hex_got[4] = hex4;
		hex_got[5] = hex5;
		assert (int'(dino_y) == exp_y) else stop_run($sformatf(
			"Mismatch at %0t: dino_y is %0d, expected %0d", $time, dino_y, exp_y));
		assert (int'(obstacle_x) == exp_x) else stop_run($sformatf(
			"Mismatch at %0t: obstacle_x is %0d, expected %0d", $time, obstacle_x, exp_x));
		assert (int'(score) == exp_score) else stop_run($sformatf(
			"Mismatch at %0t: score is %0d, expected %0d", $time, score, exp_score));
		assert (int'(high_score) == exp_high) else stop_run($sformatf(
			"Mismatch at %0t: high_score is %0d, expected %0d", $time, high_score, exp_high));
		assert (game_over == exp_over) else stop_run($sformatf(
			"Mismatch at %0t: game_over is %0b, expected %0b", $time, game_over, exp_over));
		for (int i = 0; i < 2 * dino_pkg::DIGITS; i++) begin
			value = (i < dino_pkg::DIGITS) ? exp_score : exp_high; // hex3 up is high score
			digit = (value / (10 ** (i % dino_pkg::DIGITS))) % 10;
			assert (hex_got[i] == seg_code(digit)) else stop_run($sformatf(
				"Mismatch at %0t: hex%0d is %b, expected %b", $time, i, hex_got[i],
				seg_code(digit)));
		end
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge Clock);
			cycle_count++;
		end
		stop_run("Timeout: the game did not reach the last scheduled tick in time");
	end

	initial begin
		logic [7:0] tx_byte;
		logic press;
		rst_n = 1'b0;
		uart_rxd = 1'b1;
		jump_key_n = 1'b1;
		restart_key_n = 1'b1;
		clear_model();
		uart_next_tick = 1;
		uart_jump_tick = -1;
		repeat (4) @(posedge Clock);
		rst_n <= 1'b1;
		@(negedge Clock);
		check_outputs(); // State straight out of reset
		repeat (dino_pkg::TICK_CYCLES + 1) @(posedge Clock); // First tick edge
		for (tick_num = 1; tick_num <= NUM_TICKS; tick_num++) begin
			step_game();
			if (tick_num == uart_next_tick) begin
				if (take_bits(2) != 0)
					tx_byte = dino_pkg::CMD_JUMP;
				else
					tx_byte = 8'(take_bits(8));
				if (tx_byte == dino_pkg::CMD_JUMP)
					uart_jump_tick = tick_num + UART_LAG_TICKS;
				uart_next_tick = tick_num + FRAME_TICKS + int'(take_bits(4));
				fork
					send_byte(tx_byte);
				join_none
			end
			repeat (KEY_PHASE) @(posedge Clock);
			// Favor a press that clears the coming obstacle
			if (!exp_air && !exp_over && exp_x >= 88 && exp_x <= 120)
				press = (take_bits(2) != 0);
			else
				press = (take_bits(4) == 0);
			if (press) begin
				jump_key_n <= 1'b0;
				take_off();
			end
			repeat (KEY_UP_PHASE - KEY_PHASE) @(posedge Clock);
			jump_key_n <= 1'b1;
			if (tick_num == uart_jump_tick)
				take_off(); // Byte strobe lands later in this interval
			repeat (RESTART_PHASE - KEY_UP_PHASE) @(posedge Clock);
			press = exp_over ? (take_bits(2) == 0) : (take_bits(7) == 0);
			if (press) begin
				restart_key_n <= 1'b0;
				begin_round();
			end
			repeat (RESTART_UP_PHASE - RESTART_PHASE) @(posedge Clock);
			restart_key_n <= 1'b1;
			repeat (CHECK_PHASE - RESTART_UP_PHASE) @(posedge Clock);
			@(negedge Clock);
			check_outputs();
			repeat (dino_pkg::TICK_CYCLES - CHECK_PHASE) @(posedge Clock);
		end
		$display("Regression passed");
		$finish;
	end

endmodule

//--- uart/command_decoder.sv
`timescale 1ns/1ps

module command_decoder (
	input logic Clock,
	input logic rst_n,
	input logic rx_valid,
	input logic [7:0] rx_data,
	input logic jump_key_n,
	input logic restart_key_n,
	output logic jump,
	output logic restart
);

	// Bit 0 is the jump key and bit 1 the restart key.
	// Stages 0 and 1 synchronize, stage 2 keeps the previous level
	logic [2:0][1:0] key_sync;
	logic [1:0] key_press;

	assign key_press = key_sync[2] & ~key_sync[1]; // Falling edge, keys are active low

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			key_sync <= '1;
			jump <= 1'b0;
			restart <= 1'b0;
		end else begin
			key_sync <= {key_sync[1:0], {restart_key_n, jump_key_n}};
			jump <= key_press[0] || (rx_valid && rx_data == dino_pkg::CMD_JUMP);
			restart <= key_press[1];
		end
	end

endmodule

//--- uart/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
	input logic Clock,
	input logic rst_n,
	input logic rxd,
	output logic rx_valid,
	output logic [7:0] rx_data
);

	logic [$clog2(dino_pkg::OS_DIV)-1:0] div_cnt;
	logic os_tick; // 16x the bit rate
	logic rxd_meta;
	logic rxd_sync;
	enum logic [1:0] {IDLE, START, DATA, STOP} state;
	logic [3:0] os_cnt; // Oversample ticks left in the current bit
	logic [2:0] bit_idx;
	logic [7:0] shift;

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			div_cnt <= '0;
			os_tick <= 1'b0;
		end else begin
			os_tick <= (div_cnt == dino_pkg::OS_DIV - 1);
			if (div_cnt == dino_pkg::OS_DIV - 1)
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

	// Line idles high
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			state <= IDLE;
			os_cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (os_tick) begin
				case (state)
					IDLE: if (!rxd_sync) begin
						state <= START;
						os_cnt <= 4'd7; // Wait for the middle of the start bit
					end
					START: if (os_cnt != 4'd0)
						os_cnt <= os_cnt - 1'b1;
					else if (!rxd_sync) begin
						state <= DATA;
						os_cnt <= 4'd15;
						bit_idx <= '0;
					end else
						state <= IDLE; // Glitch, not a start bit
					DATA: if (os_cnt != 4'd0)
						os_cnt <= os_cnt - 1'b1;
					else begin
						os_cnt <= 4'd15;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= STOP;
					end
					STOP: if (os_cnt != 4'd0)
						os_cnt <= os_cnt - 1'b1;
					else begin
						rx_valid <= 1'b1;
						state <= IDLE;
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

	// LSB arrives first
	always_ff @(posedge Clock) begin
		if (os_tick && state == DATA && os_cnt == 4'd0)
			shift <= {rxd_sync, shift[7:1]};
		if (os_tick && state == STOP && os_cnt == 4'd0)
			rx_data <= shift;
	end

endmodule

//--- vlog.f
+incdir+test
common/dino_pkg.sv
common/playfield_if.sv
uart/uart_rx.sv
uart/command_decoder.sv
game/dino_physics.sv
game/obstacle_mover.sv
game/referee.sv
hw/score_display.sv
hw/dino_game_top.sv
test/tb_dino_game.sv
